// File: bus_mem.f
hdl/bus_mem_pkg.sv
hdl/ap_queue.sv
hdl/ap_decode.sv
hdl/dp_ctrl.sv
hdl/mem_store.sv
hdl/bus_mem_top.sv
verification/bus_mem_assert.sv
verification/bus_mem_tb.sv

// File: verification/bus_mem_tb.sv
module bus_mem_tb import bus_mem_pkg::*; ();

	localparam int NUM_REQ         = 200;		// Requests to issue
	localparam int WATCHDOG_CYCLES = NUM_REQ * 20;

	logic			clk_i;
	logic			reset_n_i;
	bus_req_t		req_i;
	logic			grant_o;
	logic			wdata_valid_i;
	logic [DATA_W-1:0]	wdata_i;
	logic			rdata_valid_o;
	logic [DATA_W-1:0]	rdata_o;
	logic			error_o;

	integer			seed;
	int			issued;		// Requests granted so far
	logic			was_granted;

	// --------------------------------------------------
	// Reference model state
	// --------------------------------------------------

	bus_req_t		mq [$];		// Waiting requests, head first
	logic			m_grant;
	dp_state_e		m_state;
	int			m_line;		// Line of the current beat
	int			m_beats;	// Beats left
	logic			m_err;		// Current cycle is an error cycle
	logic [DATA_W-1:0]	m_rdata;
	logic [DATA_W-1:0]	m_mem [MEM_LINES];

	bus_mem_top DUT
	(
		.clk_i		(clk_i),
		.reset_n_i	(reset_n_i),
		.req_i		(req_i),
		.grant_o	(grant_o),
		.wdata_valid_i	(wdata_valid_i),
		.wdata_i	(wdata_i),
		.rdata_valid_o	(rdata_valid_o),
		.rdata_o	(rdata_o),
		.error_o	(error_o)
	);

	initial
	begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;	// Period 4
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("Timeout: the transactions did not complete in time");
		$display("TESTS FAILED");
		$fatal(1);
	end

	task automatic check_value(input string name, input logic [DATA_W-1:0] exp_v,
		input logic [DATA_W-1:0] act_v);
	begin
		if (act_v !== exp_v)
		begin
			$display("ERROR %s expected %0h actual %0h", name, exp_v, act_v);
			$display("TESTS FAILED");
			$fatal(1);
		end
	end
	endtask

	// Beat count per size code or zero when illegal
	function automatic int size_beats(input logic [SIZE_W-1:0] size);
		int n;
	begin
		case (size)
			SIZE_DW1: n = 1;
			SIZE_DW2: n = 2;
			SIZE_DW4: n = 4;
			default:  n = 0;
		endcase
		return n;
	end
	endfunction

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------

	task automatic make_request(output bus_req_t r);
		logic [31:0]	rnd;
		int		line;
	begin
		rnd  = $random(seed);
		line = rnd[19:16];
		r    = '0;
		if (rnd[27:26] != 2'b00)	// Otherwise an idle cycle
		begin
			r.read  = rnd[0];
			r.write = !rnd[0];
			if (rnd[7:4] >= 4'd13)
				r.size = rnd[13:10];	// Mostly illegal
			else if (rnd[9:8] == 2'd0)
				r.size = SIZE_DW1;
			else if (rnd[9:8] == 2'd1)
				r.size = SIZE_DW2;
			else
				r.size = SIZE_DW4;
			// Past the end
			if (rnd[23:21] == 3'd0)
				r.addr = ADDR_W'((MEM_LINES + rnd[25:24]) * LINE_BYTES);
			else
				r.addr = ADDR_W'(line * LINE_BYTES);
		end
	end
	endtask

	task automatic drive_inputs(input logic granted);
		bus_req_t	nxt;
		logic [31:0]	rnd;
	begin
		if (granted)
			issued++;
		if ((req_i.read || req_i.write) && !granted)
			nxt = req_i;		// Held until grant seen
		else if (issued < NUM_REQ)
			make_request(nxt);
		else
			nxt = '0;
		rnd = $random(seed);
		req_i         <= nxt;
		wdata_valid_i <= (rnd[1:0] != 2'b00);
		wdata_i       <= {$random(seed), $random(seed)};
	end
	endtask

	// --------------------------------------------------
	// Model step at each rising edge
	// --------------------------------------------------

	task automatic step_model();
		logic			acc;
		logic			fin;
		logic			ld;
		logic			wr_beat;
		int			wr_line;
		logic [DATA_W-1:0]	wr_data;
		bus_req_t		head;
	begin
		acc     = (req_i.read || req_i.write) && (mq.size() < AP_DEPTH) && !m_grant;
		wr_beat = (m_state == DP_WR_ACTIVE) && !m_err && wdata_valid_i;
		fin     = m_err || ((m_state == DP_RD_ACTIVE) && (m_beats == 1)) ||
			(wr_beat && (m_beats == 1));
		ld      = (mq.size() != 0) && ((m_state == DP_IDLE) || fin);
		wr_line = m_line;
		wr_data = wdata_i;
		if (ld)
		begin
			head    = mq.pop_front();
			m_beats = size_beats(head.size);
			m_err   = (m_beats == 0) ||
				(longint'(head.addr) >
				longint'((MEM_LINES - m_beats) * LINE_BYTES));
			m_line  = (head.addr / LINE_BYTES) % MEM_LINES;
			m_state = head.read ? DP_RD_ACTIVE : DP_WR_ACTIVE;
		end
		else if (fin)
		begin
			m_state = DP_IDLE;
			m_err   = 1'b0;
		end
		else if ((m_state == DP_RD_ACTIVE) || wr_beat)
		begin
			m_line  = (m_line + 1) % MEM_LINES;	// Next beat
			m_beats = m_beats - 1;
		end
		if ((m_state == DP_RD_ACTIVE) && !m_err)
			m_rdata = m_mem[m_line];	// Image read before the write lands
		if (wr_beat)
			m_mem[wr_line] = wr_data;
		m_grant = acc;
		if (acc)
			mq.push_back(req_i);
	end
	endtask

	task automatic compare_outputs();
	begin
		check_value("grant_o", m_grant, grant_o);
		check_value("error_o", m_err, error_o);
		check_value("rdata_valid_o", m_state == DP_RD_ACTIVE, rdata_valid_o);
		if (m_state == DP_RD_ACTIVE)
			check_value($sformatf("rdata_o line %0d", m_line), m_rdata, rdata_o);
	end
	endtask

	// Outputs compared at the falling edge
	initial
	begin
		@(posedge reset_n_i);
		forever
		begin
			@(negedge clk_i);
			compare_outputs();
		end
	end

	initial
	begin
		seed          = 32'hbc56_5b28;
		issued        = 0;
		reset_n_i     = 1'b0;
		req_i         = '0;
		wdata_valid_i = 1'b0;
		wdata_i       = '0;
		m_grant       = 1'b0;
		m_state       = DP_IDLE;
		m_line        = 0;
		m_beats       = 0;
		m_err         = 1'b0;
		m_rdata       = '0;
		foreach (m_mem[i])
			m_mem[i] = '0;
		repeat (2) @(posedge clk_i);
		reset_n_i <= 1'b1;
		while (!((issued == NUM_REQ) && (mq.size() == 0) && (m_state == DP_IDLE)))
		begin
			@(posedge clk_i);
			was_granted = m_grant;	// Grant seen in the cycle just ended
			step_model();
			drive_inputs(was_granted);
		end
		repeat (4) @(posedge clk_i);
		foreach (m_mem[i])
			check_value($sformatf("memory line %0d", i), m_mem[i],
				DUT.u_mem_store.mem_r[i]);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: verification/bus_mem_assert.sv
module bus_mem_assert import bus_mem_pkg::*;
(
	input  logic		clk_i,
	input  logic		reset_n_i,
	input  logic		grant_i,
	input  logic		rdata_valid_i,
	input  logic		error_i,
	input  logic [CNT_W-1:0] q_count_i	// Queue fill level
);

	// --------------------------------------------------
	// Address phase
	// --------------------------------------------------

	// Grant is a single cycle pulse
	no_double_grant: assert property (@(posedge clk_i) disable iff (!reset_n_i)
		grant_i |=> !grant_i)
		else $error("grant_o was high for two cycles in a row");

	count_bound: assert property (@(posedge clk_i) disable iff (!reset_n_i)
		q_count_i <= CNT_W'(AP_DEPTH))
		else $error("queue count went above the queue depth");

	// --------------------------------------------------
	// Response strobes
	// --------------------------------------------------

	quiet_after_reset: assert property (@(posedge clk_i)
		$rose(reset_n_i) |-> (!rdata_valid_i && !error_i))
		else $error("response strobe high in the first cycle after reset");

endmodule

bind bus_mem_top bus_mem_assert u_bus_mem_assert
(
	.clk_i		(clk_i),
	.reset_n_i	(reset_n_i),
	.grant_i	(grant_o),
	.rdata_valid_i	(rdata_valid_o),
	.error_i	(error_o),
	.q_count_i	(u_ap_queue.count_r)
);

// File: hdl/bus_mem_top.sv
module bus_mem_top import bus_mem_pkg::*;
(
	input  logic		clk_i,
	input  logic		reset_n_i,

	// Address phase
	input  bus_req_t	req_i,
	output logic		grant_o,

	// Write data
	input  logic		wdata_valid_i,
	input  logic [DATA_W-1:0] wdata_i,

	// Response
	output logic		rdata_valid_o,
	output logic [DATA_W-1:0] rdata_o,
	output logic		error_o
);

	// --------------------------------------------------
	// Internal nets
	// --------------------------------------------------

	bus_req_t		head;		// Queue head
	logic			q_empty;
	logic			pop;		// Head taken by data phase
	dp_cmd_t		cmd;		// Decoded head
	mem_wr_t		mem_wr;
	logic			rd_en;
	logic [LINE_W-1:0]	rd_line;

	ap_queue u_ap_queue
	(
		.clk_i		(clk_i),
		.reset_n_i	(reset_n_i),
		.req_i		(req_i),
		.pop_i		(pop),
		.head_o		(head),
		.empty_o	(q_empty),
		.grant_o	(grant_o)
	);

	ap_decode u_ap_decode
	(
		.head_i		(head),
		.cmd_o		(cmd)
	);

	// One transaction at a time, later ones wait in the queue
	dp_ctrl u_dp_ctrl
	(
		.clk_i		(clk_i),
		.reset_n_i	(reset_n_i),
		.cmd_i		(cmd),
		.empty_i	(q_empty),
		.wdata_valid_i	(wdata_valid_i),
		.wdata_i	(wdata_i),
		.pop_o		(pop),
		.mem_wr_o	(mem_wr),
		.rd_en_o	(rd_en),
		.rd_line_o	(rd_line),
		.rdata_valid_o	(rdata_valid_o),
		.error_o	(error_o)
	);

	mem_store u_mem_store
	(
		.clk_i		(clk_i),
		.reset_n_i	(reset_n_i),
		.wr_i		(mem_wr),
		.rd_en_i	(rd_en),
		.rd_line_i	(rd_line),
		.rdata_o	(rdata_o)
	);

endmodule

// File: hdl/mem_store.sv
module mem_store import bus_mem_pkg::*;
(
	input  logic		clk_i,
	input  logic		reset_n_i,

	// Write port
	input  mem_wr_t		wr_i,

	// Read port, data one edge later
	input  logic		rd_en_i,
	input  logic [LINE_W-1:0] rd_line_i,
	output logic [DATA_W-1:0] rdata_o
);

	// --------------------------------------------------
	// Line store
	// --------------------------------------------------

	logic [MEM_LINES-1:0][DATA_W-1:0] mem_r;	// One double word per line

	// Read samples before the write lands, so a same-edge hit returns old data
	always_ff @(posedge clk_i or negedge reset_n_i)
	begin
		if (!reset_n_i)
		begin
			mem_r   <= '0;		// Store starts cleared
			rdata_o <= '0;
		end
		else
		begin
			if (wr_i.en)
				mem_r[wr_i.line] <= wr_i.data;

			// Hold last read data between beats
			if (rd_en_i)
				rdata_o <= mem_r[rd_line_i];
		end
	end

endmodule

// File: hdl/dp_ctrl.sv
module dp_ctrl import bus_mem_pkg::*;
(
	input  logic		clk_i,
	input  logic		reset_n_i,

	// Decoded head of queue
	input  dp_cmd_t		cmd_i,
	input  logic		empty_i,	// Nothing waiting in the queue

	// Write data from the master
	input  logic		wdata_valid_i,
	input  logic [DATA_W-1:0] wdata_i,

	output logic		pop_o,		// Head loaded at this edge

	// Memory side
	output mem_wr_t		mem_wr_o,
	output logic		rd_en_o,	// Fetch rd_line_o at this edge
	output logic [LINE_W-1:0] rd_line_o,

	// Response strobes
	output logic		rdata_valid_o,
	output logic		error_o
);

	// --------------------------------------------------
	// State
	// --------------------------------------------------

	dp_state_e		state_r;
	dp_state_e		state_n;
	logic [LINE_W-1:0]	line_r;		// Line of the current beat
	logic [LINE_W-1:0]	line_n;
	logic [BEAT_W-1:0]	beats_r;	// Beats left, including the current one
	logic [BEAT_W-1:0]	beats_n;
	logic			err_r;		// Current cycle is an error cycle
	logic			err_n;

	logic			finish;		// Transaction ends at this edge
	logic			load;		// Take the head command at this edge
	logic			wr_beat;	// Write data consumed this cycle

	assign wr_beat = (state_r == DP_WR_ACTIVE) && !err_r && wdata_valid_i;

	// Last beat or error cycle
	always_comb
	begin
		finish = 1'b0;
		if (err_r)
			finish = 1'b1;		// Error lasts one cycle
		else if (state_r == DP_RD_ACTIVE)
			finish = (beats_r == BEAT_W'(1));
		else if (state_r == DP_WR_ACTIVE)
			finish = wdata_valid_i && (beats_r == BEAT_W'(1));
	end

	// Free or finishing, and something to take
	assign load  = !empty_i && ((state_r == DP_IDLE) || finish);
	assign pop_o = load;

	// --------------------------------------------------
	// Next state
	// --------------------------------------------------

	always_comb
	begin
		state_n = state_r;
		line_n  = line_r;
		beats_n = beats_r;
		err_n   = err_r;

		// Step through beats
		if ((state_r == DP_RD_ACTIVE && !err_r) || wr_beat)
		begin
			line_n  = line_r + LINE_W'(1);
			beats_n = beats_r - BEAT_W'(1);
		end

		if (load)
		begin
			// Back to back hand over, no idle cycle
			state_n = cmd_i.read ? DP_RD_ACTIVE : DP_WR_ACTIVE;
			line_n  = cmd_i.line;
			beats_n = cmd_i.beats;
			err_n   = cmd_i.err;
		end
		else if (finish)
		begin
			state_n = DP_IDLE;
			err_n   = 1'b0;
		end
	end

	always_ff @(posedge clk_i or negedge reset_n_i)
	begin
		if (!reset_n_i)
		begin
			state_r <= DP_IDLE;
			line_r  <= '0;
			beats_r <= '0;
			err_r   <= 1'b0;
		end
		else
		begin
			state_r <= state_n;
			line_r  <= line_n;
			beats_r <= beats_n;
			err_r   <= err_n;
		end
	end

	// --------------------------------------------------
	// Memory access
	// --------------------------------------------------

	// Fetch ahead so registered data lines up with the beat
	assign rd_en_o   = (state_n == DP_RD_ACTIVE) && !err_n;
	assign rd_line_o = line_n;

	always_comb
	begin
		mem_wr_o.en   = wr_beat;
		mem_wr_o.line = line_r;
		mem_wr_o.data = wdata_i;
	end

	// Response strobes, also high in a read error cycle
	assign rdata_valid_o = (state_r == DP_RD_ACTIVE);
	assign error_o       = err_r;

endmodule

// File: hdl/ap_decode.sv
module ap_decode import bus_mem_pkg::*;
(
	input  bus_req_t	head_i,		// Head of the address phase queue
	output dp_cmd_t		cmd_o		// Command for the data phase
);

	logic [BEAT_W-1:0]	beats;		// Beats from the size code
	logic			size_err;
	logic			range_err;
	logic [ADDR_W-1:0]	limit;		// Highest legal start address
	logic [ADDR_W-1:0]	line_addr;	// Address in units of lines

	// --------------------------------------------------
	// Size code to beat count
	// --------------------------------------------------

	always_comb
	begin
		beats    = '0;
		size_err = 1'b0;
		case (head_i.size)
			SIZE_DW1: beats = BEAT_W'(1);
			SIZE_DW2: beats = BEAT_W'(2);
			SIZE_DW4: beats = BEAT_W'(4);
			default:  size_err = 1'b1;	// Unsupported size
		endcase
	end

	// --------------------------------------------------
	// Range check and line index
	// --------------------------------------------------

	// Last beat has to land inside the store
	assign limit = ADDR_W'(MEM_LINES * LINE_BYTES) - (ADDR_W'(beats) * ADDR_W'(LINE_BYTES));

	assign range_err = (head_i.addr > limit);
	assign line_addr = head_i.addr / LINE_BYTES;

	always_comb
	begin
		cmd_o.read  = head_i.read;
		cmd_o.write = head_i.write;
		cmd_o.err   = size_err || range_err;
		cmd_o.line  = line_addr[LINE_W-1:0];	// Unused on error
		cmd_o.beats = beats;
	end

endmodule

// File: hdl/ap_queue.sv
module ap_queue import bus_mem_pkg::*;
(
	input  logic		clk_i,
	input  logic		reset_n_i,

	// Address phase from the master
	input  bus_req_t	req_i,
	input  logic		pop_i,		// Head taken by the data phase

	// Towards decode and data phase
	output bus_req_t	head_o,		// Oldest waiting request
	output logic		empty_o,
	output logic		grant_o		// One cycle after each accept
);

	// --------------------------------------------------
	// Storage and pointers
	// --------------------------------------------------

	bus_req_t		entry_r [AP_DEPTH];	// Waiting requests
	logic [PTR_W-1:0]	wptr_r;			// Next free slot
	logic [PTR_W-1:0]	rptr_r;			// Head slot
	logic [CNT_W-1:0]	count_r;		// Number of waiting requests
	logic			push;

	// --------------------------------------------------
	// Accept rule
	// --------------------------------------------------

	// A held request is seen again while grant_o is high, so skip that cycle
	assign push = (req_i.read || req_i.write) && (count_r < CNT_W'(AP_DEPTH)) && !grant_o;

	assign head_o  = entry_r[rptr_r];	// Valid only when not empty
	assign empty_o = (count_r == '0);

	// Slot contents
	always_ff @(posedge clk_i)
	begin
		if (push)
			entry_r[wptr_r] <= req_i;
	end

	// --------------------------------------------------
	// Pointers, count and grant
	// --------------------------------------------------

	always_ff @(posedge clk_i or negedge reset_n_i)
	begin
		if (!reset_n_i)
		begin
			wptr_r  <= '0;
			rptr_r  <= '0;
			count_r <= '0;
			grant_o <= 1'b0;
		end
		else
		begin
			// Pointers wrap by themselves since AP_DEPTH is 2**PTR_W
			if (push)
				wptr_r <= wptr_r + PTR_W'(1);
			if (pop_i)
				rptr_r <= rptr_r + PTR_W'(1);

			case ({push, pop_i})
				2'b10:   count_r <= count_r + CNT_W'(1);	// Push only
				2'b01:   count_r <= count_r - CNT_W'(1);	// Pop only
				default: count_r <= count_r;			// Both or neither
			endcase

			// Pulse for the cycle after the accepting edge
			grant_o <= push;
		end
	end

endmodule

// File: hdl/bus_mem_pkg.sv
package bus_mem_pkg;

	// --------------------------------------------------
	// Widths and sizes
	// --------------------------------------------------

	localparam int ADDR_W     = 32;		// Bus address width
	localparam int SIZE_W     = 4;		// Size code width
	localparam int DATA_W     = 64;		// One double word per line
	localparam int LINE_BYTES = 8;		// Bytes per line
	localparam int MEM_LINES  = 16;		// Lines in the store
	localparam int LINE_W     = 4;		// Line index, log2 of MEM_LINES
	localparam int BEAT_W     = 3;		// Holds a beat count up to 4

	// Address phase queue
	localparam int AP_DEPTH   = 4;		// Requests that can wait
	localparam int PTR_W      = 2;		// log2 of AP_DEPTH
	localparam int CNT_W      = 3;		// Count runs 0 to AP_DEPTH inclusive

	// --------------------------------------------------
	// Encodings
	// --------------------------------------------------

	// Supported transfer sizes, anything else is an error
	typedef enum logic [SIZE_W-1:0]
	{
		SIZE_DW1 = 4'd3,		// One double word
		SIZE_DW2 = 4'd8,		// Two double words
		SIZE_DW4 = 4'd9			// Four double words
	} size_code_e;

	typedef enum logic [1:0]
	{
		DP_IDLE      = 2'b00,		// No data phase running
		DP_RD_ACTIVE = 2'b01,		// Read beats or read error cycle
		DP_WR_ACTIVE = 2'b10		// Write beats or write error cycle
	} dp_state_e;

	// --------------------------------------------------
	// Bundles
	// --------------------------------------------------

	// Address phase request as driven by the master
	typedef struct packed
	{
		logic			read;
		logic			write;
		logic [ADDR_W-1:0]	addr;
		logic [SIZE_W-1:0]	size;		// Raw code, may be illegal
	} bus_req_t;

	// Head request after decode
	typedef struct packed
	{
		logic			read;
		logic			write;
		logic			err;		// Bad size or address out of range
		logic [LINE_W-1:0]	line;		// First line of the burst
		logic [BEAT_W-1:0]	beats;		// 1, 2 or 4
	} dp_cmd_t;

	typedef struct packed
	{
		logic			en;
		logic [LINE_W-1:0]	line;
		logic [DATA_W-1:0]	data;
	} mem_wr_t;

endpackage
